/* project.f */
+incdir+rtl
rtl/pipe_mask_pkg.sv
rtl/pkt_expect_tracker.sv
rtl/pipe_status_lane.sv
rtl/mask_sequencer.sv
rtl/pipe_mask_top.sv
tests/tb_pipe_mask_top.sv

/* rtl/mask_sequencer.sv */
`timescale 1ns/1ps
`include "pipe_mask_params.svh"

`default_nettype none

module mask_sequencer (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire [`NUM_PIPES-1:0]                  concat_en,
    input  wire [`NUM_PIPES-1:0]                  force_mask,
    input  wire [`NUM_PIPES-1:0]                  auto_mask_en,
    input  wire [`NUM_PIPES-1:0]                  restart_en,
    input  wire [`NUM_PIPES-1:0]                  frame_active,
    input  wire                                   frame_sync_lock,
    input  wire [1:0]                             aggre_mode,
    input  wire                                   latch_reset,
    input  wire [`NUM_PIPES-1:0]                  data_vld,
    input  wire [`NUM_PIPES-1:0]                  pass_bitmap,
    input  wire [`NUM_PIPES-1:0]                  fail_bitmap,
    input  wire                                   end_sch_pulse,
    output logic                                  check_start,
    output logic [`NUM_PIPES-1:0]                 watched,
    output logic [`NUM_PIPES-1:0]                 auto_en,
    output logic                                  in_init,
    output logic [`NUM_PIPES-1:0]                 mask_bitmap,
    output logic [`NUM_PIPES-1:0]                 clear_pulse,
    output logic                                  start_sch_pulse,
    output logic [`NUM_PIPES*`WR_MODE_W-1:0]      wr_mode
);

    import pipe_mask_pkg::*;

    seq_state_e state;
    seq_state_e state_nxt;

    logic [`NUM_PIPES-1:0] force_lat;
    logic [`NUM_PIPES-1:0] auto_lat;
    logic [`NUM_PIPES-1:0] normal;
    logic [`NUM_PIPES-1:0] restart;
    logic [`NUM_PIPES-1:0] mask_nxt;
    logic                  lock_ok;

    // ========================================================================
    // Pipe classes
    // ========================================================================
    assign normal  = ~mask_bitmap & concat_en;
    assign restart = mask_bitmap & restart_en & frame_active;
    assign watched = normal | restart;
    assign auto_en = auto_lat;
    assign in_init = (state == INIT);
    assign lock_ok = (aggre_mode == `AGGRE_SYNC) && frame_sync_lock;

    // Any watched pipe with data starts a check, unless a latch reset is pending
    assign check_start = (state == IDLE) && !latch_reset && |(watched & data_vld);

    // ========================================================================
    // Control FSM
    // ========================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            INIT: begin
                if (lock_ok) begin
                    state_nxt = IDLE;
                end
            end
            IDLE: begin
                if (latch_reset) begin
                    state_nxt = INIT;
                end else if (check_start) begin
                    state_nxt = STATUS;
                end
            end
            STATUS:   state_nxt = RECOVER;
            RECOVER:  state_nxt = ADD_FAIL;
            ADD_FAIL: state_nxt = CLEAR;
            CLEAR: begin
                if (&mask_bitmap) begin
                    state_nxt = INIT;
                end else if (|pass_bitmap) begin
                    state_nxt = SCHED;
                end else begin
                    state_nxt = IDLE;
                end
            end
            SCHED: begin
                if (end_sch_pulse) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = INIT;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= INIT;
        end else begin
            state <= state_nxt;
        end
    end

    // Configuration tracks its inputs while in INIT and freezes afterwards
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            force_lat <= '0;
            auto_lat  <= '0;
        end else if (state == INIT) begin
            force_lat <= force_mask;
            auto_lat  <= auto_mask_en;
        end
    end

    // ========================================================================
    // Mask bitmap and output pulses
    // ========================================================================
    always_comb begin
        mask_nxt = mask_bitmap;
        case (state)
            INIT:     if (lock_ok) mask_nxt = concat_en & force_lat;
            RECOVER:  mask_nxt = mask_bitmap & ~(restart & pass_bitmap);
            ADD_FAIL: mask_nxt = mask_bitmap | (normal & fail_bitmap);
            default:  mask_nxt = mask_bitmap;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask_bitmap     <= '1;
            clear_pulse     <= '0;
            start_sch_pulse <= 1'b0;
        end else begin
            mask_bitmap     <= mask_nxt;
            // Clear carries the final mask for one cycle in CLEAR
            clear_pulse     <= (state == ADD_FAIL) ? mask_nxt : '0;
            start_sch_pulse <= (state == CLEAR) && (state_nxt == SCHED);
        end
    end

    // Masked pipes without restart are not written
    always_comb begin
        for (int i = 0; i < `NUM_PIPES; i++) begin
            if (in_init || (mask_bitmap[i] && !restart_en[i])) begin
                wr_mode[i*`WR_MODE_W +: `WR_MODE_W] = `WR_MODE_OFF;
            end else begin
                wr_mode[i*`WR_MODE_W +: `WR_MODE_W] = `WR_MODE_ON;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/pipe_mask_params.svh */
`ifndef PIPE_MASK_PARAMS_SVH
`define PIPE_MASK_PARAMS_SVH

`default_nettype none

// Pipe count and field widths
`define NUM_PIPES   4
`define DT_W        6
`define CNT_W       16
`define WR_MODE_W   2

// Short packet datatype codes
`define DT_FS       6'h00
`define DT_FE       6'h01

// Per-pipe write mode codes
`define WR_MODE_OFF 2'd0
`define WR_MODE_ON  2'd2

// Aggregation mode that enables masking
`define AGGRE_SYNC  2'd1

`default_nettype wire

`endif

/* rtl/pipe_mask_pkg.sv */
`include "pipe_mask_params.svh"

`default_nettype none

package pipe_mask_pkg;

    // Frame start / frame end packet
    typedef struct packed {
        logic [`DT_W-1:0]  datatype;
        logic [`CNT_W-1:0] reserved;
        logic [`CNT_W-1:0] framecount;
    } short_pkt_t;

    // Line packet
    typedef struct packed {
        logic [`DT_W-1:0]  datatype;
        logic [`CNT_W-1:0] linecount;
        logic [`CNT_W-1:0] wordcount;
    } long_pkt_t;

    // One status word per pipe, read either way
    typedef union packed {
        short_pkt_t short_view;
        long_pkt_t  long_view;
    } pkt_word_u;

    typedef enum logic [2:0] {
        INIT, IDLE, STATUS, RECOVER, ADD_FAIL, CLEAR, SCHED
    } seq_state_e;

    typedef enum logic [1:0] {
        PH_IDLE, PH_FS, PH_LONG, PH_FE
    } pkt_phase_e;

endpackage

`default_nettype wire

/* rtl/pipe_mask_top.sv */
`timescale 1ns/1ps
`include "pipe_mask_params.svh"

`default_nettype none

module pipe_mask_top (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire [`NUM_PIPES-1:0]              concat_en,
    input  wire [`NUM_PIPES-1:0]              force_mask,
    input  wire [`NUM_PIPES-1:0]              auto_mask_en,
    input  wire [`NUM_PIPES-1:0]              restart_en,
    input  wire [`NUM_PIPES-1:0]              frame_active,
    input  wire                               frame_sync_lock,
    input  wire [1:0]                         aggre_mode,
    input  wire                               latch_reset,
    input  wire [`NUM_PIPES-1:0]              data_vld,
    input  wire pipe_mask_pkg::pkt_word_u     data_0,
    input  wire pipe_mask_pkg::pkt_word_u     data_1,
    input  wire pipe_mask_pkg::pkt_word_u     data_2,
    input  wire pipe_mask_pkg::pkt_word_u     data_3,
    input  wire [`CNT_W-1:0]                  lines_per_frame,
    input  wire [`DT_W-1:0]                   long_datatype,
    input  wire                               check_framecount,
    input  wire                               check_linecount,
    input  wire                               end_sch_pulse,
    output wire [`NUM_PIPES-1:0]              mask_bitmap,
    output wire [`NUM_PIPES-1:0]              clear_pulse,
    output wire                               start_sch_pulse,
    output wire [`NUM_PIPES*`WR_MODE_W-1:0]   wr_mode,
    output wire [`NUM_PIPES-1:0]              status_pass_bitmap,
    output wire [`CNT_W-1:0]                  local_framecount,
    output wire [`CNT_W-1:0]                  local_linecount,
    output wire [`DT_W-1:0]                   local_pkt_datatype
);

    import pipe_mask_pkg::*;

    pkt_word_u             pipe_data [`NUM_PIPES];
    wire [`CNT_W-1:0]      exp_count;
    wire                   count_check;
    wire                   exp_is_long;
    wire                   check_start;
    wire                   in_init;
    wire [`NUM_PIPES-1:0]  watched;
    wire [`NUM_PIPES-1:0]  auto_en;
    wire [`NUM_PIPES-1:0]  fail_bitmap;

    assign pipe_data[0] = data_0;
    assign pipe_data[1] = data_1;
    assign pipe_data[2] = data_2;
    assign pipe_data[3] = data_3;

    // Expected packet, advanced by each schedule start
    pkt_expect_tracker u_tracker (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_init          (in_init),
        .sched_start      (start_sch_pulse),
        .lines_per_frame  (lines_per_frame),
        .long_datatype    (long_datatype),
        .check_framecount (check_framecount),
        .check_linecount  (check_linecount),
        .exp_datatype     (local_pkt_datatype),
        .exp_count        (exp_count),
        .count_check      (count_check),
        .exp_is_long      (exp_is_long),
        .framecount       (local_framecount),
        .linecount        (local_linecount)
    );

    for (genvar i = 0; i < `NUM_PIPES; i++) begin : g_lane
        pipe_status_lane u_lane (
            .clk          (clk),
            .rst_n        (rst_n),
            .check_start  (check_start),
            .watched      (watched[i]),
            .auto_en      (auto_en[i]),
            .data_vld     (data_vld[i]),
            .data         (pipe_data[i]),
            .exp_datatype (local_pkt_datatype),
            .exp_count    (exp_count),
            .count_check  (count_check),
            .exp_is_long  (exp_is_long),
            .pass         (status_pass_bitmap[i]),
            .fail         (fail_bitmap[i])
        );
    end

    mask_sequencer u_sequencer (
        .clk             (clk),
        .rst_n           (rst_n),
        .concat_en       (concat_en),
        .force_mask      (force_mask),
        .auto_mask_en    (auto_mask_en),
        .restart_en      (restart_en),
        .frame_active    (frame_active),
        .frame_sync_lock (frame_sync_lock),
        .aggre_mode      (aggre_mode),
        .latch_reset     (latch_reset),
        .data_vld        (data_vld),
        .pass_bitmap     (status_pass_bitmap),
        .fail_bitmap     (fail_bitmap),
        .end_sch_pulse   (end_sch_pulse),
        .check_start     (check_start),
        .watched         (watched),
        .auto_en         (auto_en),
        .in_init         (in_init),
        .mask_bitmap     (mask_bitmap),
        .clear_pulse     (clear_pulse),
        .start_sch_pulse (start_sch_pulse),
        .wr_mode         (wr_mode)
    );

endmodule

`default_nettype wire

/* rtl/pipe_status_lane.sv */
`timescale 1ns/1ps
`include "pipe_mask_params.svh"

`default_nettype none

module pipe_status_lane (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      check_start,
    input  wire                      watched,
    input  wire                      auto_en,
    input  wire                      data_vld,
    input  wire pipe_mask_pkg::pkt_word_u data,
    input  wire [`DT_W-1:0]          exp_datatype,
    input  wire [`CNT_W-1:0]         exp_count,
    input  wire                      count_check,
    input  wire                      exp_is_long,
    output logic                     pass,
    output logic                     fail
);

    logic [`DT_W-1:0]  rx_datatype;
    logic [`CNT_W-1:0] rx_count;
    logic              match;
    logic              pass_now;

    // Pick the view that the expected phase calls for
    assign rx_datatype = exp_is_long ? data.long_view.datatype : data.short_view.datatype;
    assign rx_count    = exp_is_long ? data.long_view.linecount : data.short_view.framecount;

    assign match    = (rx_datatype == exp_datatype) &&
                      (!count_check || (rx_count == exp_count));
    assign pass_now = watched && data_vld && match;

    // Verdict held until the next check
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pass <= 1'b0;
            fail <= 1'b0;
        end else if (check_start) begin
            pass <= pass_now;
            fail <= watched && auto_en && !pass_now;
        end
    end

endmodule

`default_nettype wire

/* rtl/pkt_expect_tracker.sv */
`timescale 1ns/1ps
`include "pipe_mask_params.svh"

`default_nettype none

module pkt_expect_tracker (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               in_init,
    input  wire               sched_start,
    input  wire [`CNT_W-1:0]  lines_per_frame,
    input  wire [`DT_W-1:0]   long_datatype,
    input  wire               check_framecount,
    input  wire               check_linecount,
    output logic [`DT_W-1:0]  exp_datatype,
    output logic [`CNT_W-1:0] exp_count,
    output logic              count_check,
    output logic              exp_is_long,
    output logic [`CNT_W-1:0] framecount,
    output logic [`CNT_W-1:0] linecount
);

    import pipe_mask_pkg::*;

    pkt_phase_e phase;
    pkt_phase_e phase_nxt;

    // ========================================================================
    // Expected packet phase runs FS, lines 0..N, FE
    // ========================================================================
    always_comb begin
        phase_nxt = phase;
        case (phase)
            PH_IDLE: phase_nxt = PH_FS;
            PH_FS:   if (sched_start) phase_nxt = PH_LONG;
            PH_LONG: if (sched_start && (linecount == lines_per_frame)) phase_nxt = PH_FE;
            PH_FE:   if (sched_start) phase_nxt = PH_FS;
            default: phase_nxt = PH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PH_IDLE;
        end else if (in_init) begin
            phase <= PH_IDLE;
        end else begin
            phase <= phase_nxt;
        end
    end

    // Line count restarts at frame start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            linecount <= '0;
        end else if (sched_start && (phase == PH_FS)) begin
            linecount <= '0;
        end else if (sched_start && (phase == PH_LONG)) begin
            linecount <= linecount + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            framecount <= '0;
        end else if (in_init) begin
            framecount <= '0;
        end else if (sched_start && (phase == PH_FE)) begin
            framecount <= framecount + 1'b1;
        end
    end

    // ========================================================================
    // Expected packet broadcast to the lanes
    // ========================================================================
    assign exp_is_long  = (phase == PH_LONG);
    assign exp_datatype = (phase == PH_FE)   ? `DT_FE :
                          (phase == PH_LONG) ? long_datatype : `DT_FS;
    assign exp_count    = (phase == PH_LONG) ? linecount : framecount;
    // Short phases check the frame count, the long phase the line count
    assign count_check  = (((phase == PH_FS) || (phase == PH_FE)) && check_framecount) ||
                          (exp_is_long && check_linecount);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f project.f --top-module tb_pipe_mask_top \
    -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "Everything OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* tests/tb_pipe_mask_top.sv */
`timescale 1ns/1ps
`include "pipe_mask_params.svh"

`default_nettype none

module tb_pipe_mask_top;

    import pipe_mask_pkg::*;

    localparam int NUM_TESTS = 6;

    logic                              clk;
    logic                              rst_n;
    logic [`NUM_PIPES-1:0]             concat_en;
    logic [`NUM_PIPES-1:0]             force_mask;
    logic [`NUM_PIPES-1:0]             auto_mask_en;
    logic [`NUM_PIPES-1:0]             restart_en;
    logic [`NUM_PIPES-1:0]             frame_active;
    logic                              frame_sync_lock;
    logic [1:0]                        aggre_mode;
    logic                              latch_reset;
    logic [`NUM_PIPES-1:0]             data_vld;
    pkt_word_u                         data_w [`NUM_PIPES];
    logic [`CNT_W-1:0]                 lines_per_frame;
    logic [`DT_W-1:0]                  long_datatype;
    logic                              check_framecount;
    logic                              check_linecount;
    logic                              end_sch_pulse;
    wire [`NUM_PIPES-1:0]              mask_bitmap;
    wire [`NUM_PIPES-1:0]              clear_pulse;
    wire                               start_sch_pulse;
    wire [`NUM_PIPES*`WR_MODE_W-1:0]   wr_mode;
    wire [`NUM_PIPES-1:0]              status_pass_bitmap;
    wire [`CNT_W-1:0]                  local_framecount;
    wire [`CNT_W-1:0]                  local_linecount;
    wire [`DT_W-1:0]                   local_pkt_datatype;

    // Expected state kept by the testbench
    logic [`NUM_PIPES-1:0] exp_mask;
    logic [`NUM_PIPES-1:0] auto_cfg;
    logic [`NUM_PIPES-1:0] exp_clear;
    logic                  exp_sched;
    pkt_phase_e            exp_phase;
    logic [`CNT_W-1:0]     exp_fc;
    logic [`CNT_W-1:0]     exp_lc;
    int                    cyc = 0;
    int                    t_cyc;
    int                    err_count;
    int                    n_checks;
    int                    tests_done;

    pipe_mask_top DUT (
        .clk (clk), .rst_n (rst_n),
        .concat_en (concat_en), .force_mask (force_mask), .auto_mask_en (auto_mask_en),
        .restart_en (restart_en), .frame_active (frame_active),
        .frame_sync_lock (frame_sync_lock), .aggre_mode (aggre_mode),
        .latch_reset (latch_reset), .data_vld (data_vld),
        .data_0 (data_w[0]), .data_1 (data_w[1]), .data_2 (data_w[2]), .data_3 (data_w[3]),
        .lines_per_frame (lines_per_frame), .long_datatype (long_datatype),
        .check_framecount (check_framecount), .check_linecount (check_linecount),
        .end_sch_pulse (end_sch_pulse),
        .mask_bitmap (mask_bitmap), .clear_pulse (clear_pulse),
        .start_sch_pulse (start_sch_pulse), .wr_mode (wr_mode),
        .status_pass_bitmap (status_pass_bitmap), .local_framecount (local_framecount),
        .local_linecount (local_linecount), .local_pkt_datatype (local_pkt_datatype)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // ========================================================================
    // Compare tasks
    // ========================================================================
    task automatic check_bitmap(input logic [`NUM_PIPES-1:0] got, exp, input string what);
        n_checks++;
        if (got !== exp) begin
            err_count++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input logic [`CNT_W-1:0] got, exp, input string what);
        n_checks++;
        if (got !== exp) begin
            err_count++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_datatype(input logic [`DT_W-1:0] got, exp, input string what);
        n_checks++;
        if (got !== exp) begin
            err_count++;
            $display("Mismatch at %0t: %s is 0x%h, expected 0x%h", $time, what, got, exp);
        end
    endtask

    task automatic check_wr_mode(input logic [`NUM_PIPES*`WR_MODE_W-1:0] got, exp,
                                 input string what);
        n_checks++;
        if (got !== exp) begin
            err_count++;
            $display("Mismatch at %0t: %s is 0x%h, expected 0x%h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, exp, input string what);
        n_checks++;
        if (got !== exp) begin
            err_count++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ========================================================================
    // Reference model
    // ========================================================================
    // Lane verdicts for all pipes, returned as {pass, fail}
    function automatic logic [2*`NUM_PIPES-1:0] ref_verdict(
        input pkt_word_u             w [`NUM_PIPES],
        input logic [`NUM_PIPES-1:0] vld,
        input logic [`NUM_PIPES-1:0] watch,
        input logic [`NUM_PIPES-1:0] auto,
        input logic [`DT_W-1:0]      dt,
        input logic [`CNT_W-1:0]     cnt,
        input logic                  is_long,
        input logic                  cnt_chk
    );
        logic [`NUM_PIPES-1:0] p;
        logic [`NUM_PIPES-1:0] f;
        logic [`DT_W-1:0]      rx_dt;
        logic [`CNT_W-1:0]     rx_cnt;
        logic                  hit;
        for (int i = 0; i < `NUM_PIPES; i++) begin
            rx_dt  = is_long ? w[i].long_view.datatype : w[i].short_view.datatype;
            rx_cnt = is_long ? w[i].long_view.linecount : w[i].short_view.framecount;
            hit    = (rx_dt == dt) && (!cnt_chk || (rx_cnt == cnt));
            p[i]   = watch[i] && vld[i] && hit;
            f[i]   = watch[i] && auto[i] && !p[i];
        end
        return {p, f};
    endfunction

    function automatic logic [`NUM_PIPES*`WR_MODE_W-1:0] expected_wr_mode(
        input logic [`NUM_PIPES-1:0] mask,
        input logic [`NUM_PIPES-1:0] ren,
        input logic                  init
    );
        logic [`NUM_PIPES*`WR_MODE_W-1:0] wm;
        for (int i = 0; i < `NUM_PIPES; i++) begin
            if (init || (mask[i] && !ren[i])) begin
                wm[i*`WR_MODE_W +: `WR_MODE_W] = `WR_MODE_OFF;
            end else begin
                wm[i*`WR_MODE_W +: `WR_MODE_W] = `WR_MODE_ON;
            end
        end
        return wm;
    endfunction

    function automatic logic [`DT_W-1:0] model_datatype();
        if (exp_phase == PH_FE) begin
            return `DT_FE;
        end
        return (exp_phase == PH_LONG) ? long_datatype : `DT_FS;
    endfunction

    function automatic logic [`CNT_W-1:0] model_count();
        return (exp_phase == PH_LONG) ? exp_lc : exp_fc;
    endfunction

    // Unused fields get random filler
    function automatic pkt_word_u packet_for(input pkt_phase_e ph, input logic [`DT_W-1:0] dt,
                                             input logic [`CNT_W-1:0] cnt);
        pkt_word_u w;
        if (ph == PH_LONG) begin
            w.long_view.datatype  = dt;
            w.long_view.linecount = cnt;
            w.long_view.wordcount = 16'($urandom);
        end else begin
            w.short_view.datatype   = dt;
            w.short_view.reserved   = 16'($urandom);
            w.short_view.framecount = cnt;
        end
        return w;
    endfunction

    task automatic advance_tracker_model();
        case (exp_phase)
            PH_FS: begin
                exp_lc    = '0;
                exp_phase = PH_LONG;
            end
            PH_LONG: begin
                if (exp_lc == lines_per_frame) begin
                    exp_phase = PH_FE;
                end
                exp_lc = exp_lc + 16'd1;
            end
            PH_FE: begin
                exp_fc    = exp_fc + 16'd1;
                exp_phase = PH_FS;
            end
            default: ;
        endcase
    endtask

    // Clear and schedule pulses must appear exactly on their cycle
    always @(negedge clk) begin
        if (rst_n) begin
            check_bitmap(clear_pulse, (cyc == t_cyc + 3) ? exp_clear : '0, "clear_pulse");
            check_flag(start_sch_pulse, exp_sched && (cyc == t_cyc + 4), "start_sch_pulse");
        end
    end

    initial begin
        #(NUM_TESTS * 400 * 20);
        $display("Watchdog expired before the tests completed");
        $display("Something failed");
        $finish;
    end

    // ========================================================================
    // Stimulus tasks
    // ========================================================================
    task automatic do_lock();
        aggre_mode      = `AGGRE_SYNC;
        frame_sync_lock = 1'b1;
        @(negedge clk);
        exp_mask  = concat_en & force_mask;
        auto_cfg  = auto_mask_en;
        exp_phase = PH_FS;
        exp_fc    = '0;
        check_bitmap(mask_bitmap, exp_mask, "mask_bitmap after lock");
        check_wr_mode(wr_mode, expected_wr_mode(exp_mask, restart_en, 1'b0), "wr_mode");
        repeat (2) @(negedge clk);
    endtask

    task automatic load_good_words();
        for (int i = 0; i < `NUM_PIPES; i++) begin
            data_w[i] = packet_for(exp_phase, model_datatype(), model_count());
        end
    endtask

    // One status check from trigger to the end of the round
    task automatic run_round(input logic [`NUM_PIPES-1:0] vld);
        logic [`NUM_PIPES-1:0]   normal;
        logic [`NUM_PIPES-1:0]   restart;
        logic [`NUM_PIPES-1:0]   p;
        logic [`NUM_PIPES-1:0]   f;
        logic [`NUM_PIPES-1:0]   m_next;
        logic [2*`NUM_PIPES-1:0] verdict;
        int                      waited;
        normal  = ~exp_mask & concat_en;
        restart = exp_mask & restart_en & frame_active;
        verdict = ref_verdict(data_w, vld, normal | restart, auto_cfg, model_datatype(),
                              model_count(), exp_phase == PH_LONG,
                              (exp_phase == PH_LONG) ? check_linecount : check_framecount);
        p       = verdict[2*`NUM_PIPES-1:`NUM_PIPES];
        f       = verdict[`NUM_PIPES-1:0];
        m_next  = (exp_mask & ~(restart & p)) | (normal & f);
        // Trigger edge is the next rising edge
        t_cyc     = cyc + 1;
        exp_clear = m_next;
        exp_sched = !(&m_next) && (|p);
        data_vld  = vld;
        @(negedge clk);
        data_vld = '0;
        check_bitmap(status_pass_bitmap, p, "status_pass_bitmap");
        exp_mask = m_next;
        if (exp_sched) begin
            waited = 0;
            while (!start_sch_pulse && (waited < 10)) begin
                @(negedge clk);
                waited++;
            end
            if (!start_sch_pulse) begin
                err_count++;
                $display("No schedule start seen after the status check at %0t", $time);
            end
            advance_tracker_model();
            // Schedule round latency varies
            repeat ($urandom_range(4)) @(negedge clk);
            end_sch_pulse = 1'b1;
            @(negedge clk);
            end_sch_pulse = 1'b0;
            @(negedge clk);
        end else begin
            repeat (5) @(negedge clk);
            if (&m_next) begin
                exp_phase = PH_IDLE;
                exp_fc    = '0;
            end
        end
        check_bitmap(mask_bitmap, exp_mask, "mask_bitmap");
        check_wr_mode(wr_mode, expected_wr_mode(exp_mask, restart_en, &exp_mask), "wr_mode");
        check_count(local_framecount, exp_fc, "local_framecount");
        check_count(local_linecount, exp_lc, "local_linecount");
        check_datatype(local_pkt_datatype, model_datatype(), "local_pkt_datatype");
    endtask

    task automatic test_done(input string name);
        tests_done++;
        $display("Test %0d (%s) done, %0d errors so far", tests_done, name, err_count);
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        void'($urandom(43130));
        clk = 1'b0;
        rst_n = 1'b0;
        concat_en = 4'b1111;
        force_mask = 4'b1000;
        auto_mask_en = 4'b1011;
        restart_en = '0;
        frame_active = '0;
        frame_sync_lock = 1'b0;
        aggre_mode = 2'd0;
        latch_reset = 1'b0;
        data_vld = '0;
        for (int i = 0; i < `NUM_PIPES; i++) begin
            data_w[i] = '0;
        end
        lines_per_frame = 16'd5;
        long_datatype = 6'h2b;
        check_framecount = 1'b1;
        check_linecount = 1'b1;
        end_sch_pulse = 1'b0;
        exp_mask = '1;
        auto_cfg = '0;
        exp_clear = '0;
        exp_sched = 1'b0;
        exp_phase = PH_IDLE;
        exp_fc = '0;
        exp_lc = '0;
        t_cyc = -100;
        err_count = 0;
        n_checks = 0;
        tests_done = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Reset values, then a lock attempt with the wrong mode
        check_bitmap(mask_bitmap, 4'b1111, "mask_bitmap after reset");
        check_wr_mode(wr_mode, '0, "wr_mode after reset");
        check_bitmap(status_pass_bitmap, '0, "status_pass_bitmap after reset");
        check_count(local_framecount, '0, "local_framecount after reset");
        check_count(local_linecount, '0, "local_linecount after reset");
        frame_sync_lock = 1'b1;
        repeat (3) @(negedge clk);
        check_bitmap(mask_bitmap, 4'b1111, "mask_bitmap without sync mode");
        do_lock();
        check_wr_mode(wr_mode, 8'h2a, "wr_mode after lock");
        test_done("reset and lock");

        load_good_words();
        run_round(4'b1111);
        test_done("good frame start");

        // Pipe 1 gets a bad datatype, pipe 2 a bad count without auto-mask
        load_good_words();
        data_w[1] = packet_for(PH_LONG, 6'h3f, exp_lc);
        run_round(4'b1111);
        check_bitmap(mask_bitmap, 4'b1010, "mask_bitmap after auto-mask");
        load_good_words();
        data_w[2] = packet_for(PH_LONG, long_datatype, exp_lc + 16'd5);
        run_round(4'b1111);
        check_bitmap(mask_bitmap, 4'b1010, "mask_bitmap with auto-mask off");
        test_done("auto-mask");

        restart_en   = 4'b0010;
        frame_active = 4'b0010;
        load_good_words();
        run_round(4'b1111);
        check_bitmap(mask_bitmap, 4'b1000, "mask_bitmap after restart");
        test_done("restart");

        // Rest of the frame, then a frame with count checks off
        while (exp_phase != PH_FS) begin
            load_good_words();
            run_round(4'b1111);
        end
        load_good_words();
        run_round(4'b1111);
        check_linecount = 1'b0;
        while (exp_phase == PH_LONG) begin
            load_good_words();
            data_w[0] = packet_for(exp_phase, model_datatype(), model_count() + 16'd7);
            run_round(4'b1111);
        end
        check_linecount  = 1'b1;
        check_framecount = 1'b0;
        load_good_words();
        data_w[0] = packet_for(exp_phase, model_datatype(), model_count() + 16'd7);
        run_round(4'b1111);
        check_framecount = 1'b1;
        load_good_words();
        run_round(4'b1111);
        test_done("full frame");

        frame_sync_lock = 1'b0;
        latch_reset     = 1'b1;
        @(negedge clk);
        latch_reset = 1'b0;
        check_wr_mode(wr_mode, '0, "wr_mode in INIT");
        check_bitmap(mask_bitmap, exp_mask, "mask_bitmap in INIT");
        auto_mask_en = 4'b1111;
        repeat (3) @(negedge clk);
        exp_phase = PH_IDLE;
        exp_fc    = '0;
        check_count(local_framecount, '0, "local_framecount in INIT");
        do_lock();
        // Every watched pipe fails, so CLEAR falls back to INIT
        frame_sync_lock = 1'b0;
        for (int i = 0; i < `NUM_PIPES; i++) begin
            data_w[i] = packet_for(exp_phase, 6'h3e, model_count());
        end
        run_round(4'b1111);
        check_bitmap(mask_bitmap, 4'b1111, "mask_bitmap after all pipes fail");
        check_wr_mode(wr_mode, '0, "wr_mode after all pipes fail");
        test_done("return to INIT");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests_done, n_checks, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
